/* kl_mem.f */
+incdir+verilog
verilog/kl_mem_pkg.sv
verilog/mbox_mem_port.sv
verilog/mt0.sv
verilog/sbus_mem.sv
verilog/kl_mem_top.sv
verification/tb_kl_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_kl_mem -Mdir obj_dir -f kl_mem.f &&
./obj_dir/Vtb_kl_mem | tee /dev/stderr | grep -x "=== PASS ===" > /dev/null &&
echo "kl_mem simulation passed" ||
{ echo "kl_mem simulation failed"; exit 1; }

/* verification/tb_kl_mem.sv */
`default_nettype none

`include "kl_mem_defs.svh"

module tb_kl_mem;

  import kl_mem_pkg::*;

  // Longest wait for an ack edge, in clock cycles
  localparam int TIMEOUT = 40;

  logic      sbus_clk;
  logic      arst_n;
  logic      req;
  host_req_t host_req;
  logic      ack;
  host_rsp_t host_rsp;
  integer    seed;

  // Expected storage contents, indexed by the low PMA bits as in the memory
  word_t     model [0:(1 << `MEM_ADR_W) - 1];

  kl_mem_top i_dut (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .req      (req),
    .host_req (host_req),
    .ack      (ack),
    .host_rsp (host_rsp)
  );

  initial begin
    sbus_clk = 1'b0;
    forever #50 sbus_clk = ~sbus_clk;
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Counts falling edges until ack reaches level
  // Outputs are sampled half a cycle away from the driving edge
  task automatic wait_ack(input logic level, output int cycles);
    cycles = 0;
    @(negedge sbus_clk);
    while (ack !== level) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timed out waiting for ack to become %0b", level);
        $display("=== FAIL ===");
        $fatal(1, "no ack edge");
      end
      @(negedge sbus_clk);
    end
  endtask

  function automatic word_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[`WORD_W-1:0];
  endfunction

  function automatic pma_t rand_pma();
    logic [31:0] r;
    r = $random(seed);
    return r[`PMA_W-1:0];
  endfunction

  // One four-phase host cycle, response taken while ack is high
  task automatic host_cycle(input string name, input logic wr, input logic bad_par,
                            input pma_t pma, input word_t data,
                            output host_rsp_t rsp, output int cycles);
    int fall;
    @(posedge sbus_clk);
    req      <= 1'b1;
    host_req <= '{wr: wr, bad_adr_par: bad_par, pma: pma, data: data};
    wait_ack(1'b1, cycles);
    rsp = host_rsp;
    @(posedge sbus_clk);
    req <= 1'b0;
    wait_ack(1'b0, fall);
    // Ack drops in the cycle after req
    check({name, " ack fall"}, 64'(1), 64'(fall));
  endtask

  // Good-parity read or write, checked against the model
  task automatic mem_access(input string name, input logic wr, input pma_t pma,
                            input word_t data);
    host_rsp_t rsp;
    int        cycles;
    host_cycle(name, wr, 1'b0, pma, data, rsp, cycles);
    check({name, " latency"}, 64'(6), 64'(cycles));
    check({name, " adr_par_err"}, 64'(0), 64'(rsp.adr_par_err));
    if (wr) begin
      model[pma[`MEM_ADR_W-1:0]] = data;
    end else begin
      check({name, " data"}, 64'(model[pma[`MEM_ADR_W-1:0]]), 64'(rsp.data));
      check({name, " data_par_err"}, 64'(0), 64'(rsp.data_par_err));
    end
  endtask

  task automatic write_then_read();
    pma_t adr;
    adr = rand_pma();
    mem_access("write_then_read wr", 1'b1, adr, rand_word());
    mem_access("write_then_read rd", 1'b0, adr, '0);
  endtask

  task automatic multi_address();
    pma_t     adr_q [$];
    pma_t     adr;
    mem_adr_t base;
    base = mem_adr_t'(rand_pma());
    for (int i = 0; i < 16; i++) begin
      adr = rand_pma();
      // Step of 17 keeps all 16 storage indexes apart
      adr[`MEM_ADR_W-1:0] = base + mem_adr_t'(17 * i);
      adr_q.push_back(adr);
      mem_access("multi_address wr", 1'b1, adr, rand_word());
    end
    // Step of 7 visits every entry, out of write order
    for (int i = 0; i < 16; i++) begin
      mem_access("multi_address rd", 1'b0, adr_q[(i * 7 + 3) % 16], '0);
    end
  endtask

  task automatic address_aliasing();
    pma_t adr;
    pma_t alias_adr;
    adr = rand_pma();
    // Bit MEM_ADR_W always flips, upper bits at random
    alias_adr = adr ^ (pma_t'($random(seed) | 1) << `MEM_ADR_W);
    mem_access("address_aliasing wr", 1'b1, adr, rand_word());
    mem_access("address_aliasing rd", 1'b0, alias_adr, '0);
  endtask

  task automatic forced_bad_parity();
    pma_t      adr;
    host_rsp_t rsp;
    int        cycles;
    adr = rand_pma();
    mem_access("forced_bad_parity wr", 1'b1, adr, rand_word());
    host_cycle("forced_bad_parity", 1'b1, 1'b1, adr, rand_word(), rsp, cycles);
    // No data phase after an address error
    check("forced_bad_parity latency", 64'(5), 64'(cycles));
    check("forced_bad_parity adr_par_err", 64'(1), 64'(rsp.adr_par_err));
    // Old word survives the refused write
    mem_access("forced_bad_parity rd", 1'b0, adr, '0);
  endtask

  task automatic handshake_rules();
    pma_t  adr;
    pma_t  other;
    word_t w;
    int    cycles;
    adr   = rand_pma();
    other = adr ^ pma_t'(1);
    w     = rand_word();
    mem_access("handshake wr", 1'b1, adr, w);
    mem_access("handshake wr other", 1'b1, other, rand_word());
    @(posedge sbus_clk);
    req      <= 1'b1;
    host_req <= '{wr: 1'b0, bad_adr_par: 1'b0, pma: adr, data: '0};
    wait_ack(1'b1, cycles);
    check("handshake rd data", 64'(w), 64'(host_rsp.data));
    // Swap in a write while ack is still high
    @(posedge sbus_clk);
    host_req <= '{wr: 1'b1, bad_adr_par: 1'b0, pma: other, data: ~w};
    repeat (4) begin
      @(negedge sbus_clk);
      check("handshake ack held", 64'(1), 64'(ack));
    end
    @(posedge sbus_clk);
    req <= 1'b0;
    wait_ack(1'b0, cycles);
    check("handshake ack fall", 64'(1), 64'(cycles));
    // Quiet bus, no second ack
    repeat (8) begin
      @(negedge sbus_clk);
      check("handshake second ack", 64'(0), 64'(ack));
    end
    // The swapped-in write never ran
    mem_access("handshake rd other", 1'b0, other, '0);
  endtask

  initial begin
    seed     = 32'h31b8_da57;
    arst_n   = 1'b0;
    req      = 1'b0;
    host_req = '0;
    repeat (4) @(posedge sbus_clk);
    arst_n <= 1'b1;
    @(negedge sbus_clk);
    check("reset ack", 64'(0), 64'(ack));
    write_then_read();
    multi_address();
    address_aliasing();
    forced_bad_parity();
    handshake_rules();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/kl_mem_top.sv */
`default_nettype none

// Host port, MBOX memory port, translator and SBUS storage
module kl_mem_top (
  input  wire                   sbus_clk,
  input  wire                   arst_n,
  input  wire                   req,
  input  kl_mem_pkg::host_req_t host_req,
  output logic                  ack,
  output kl_mem_pkg::host_rsp_t host_rsp
);

  import kl_mem_pkg::*;

  // MBOX side of the translator
  mbox_mem_t    mbox_out;
  mbox_mem_in_t mbox_in;

  // SBUS side of the translator
  sbus_cmd_t    sbus_cmd;
  sbus_rsp_t    sbus_rsp;

  // Host requests become SBUS cycles here
  mbox_mem_port i_mbox_mem_port (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .req      (req),
    .host_req (host_req),
    .mem_in   (mbox_in),
    .ack      (ack),
    .host_rsp (host_rsp),
    .mem_out  (mbox_out)
  );

  // Name change, address register and data steering
  mt0 i_mt0 (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .mbox     (mbox_out),
    .sbus_in  (sbus_rsp),
    .mbox_in  (mbox_in),
    .sbus_out (sbus_cmd)
  );

  // Storage on the SBUS
  sbus_mem i_sbus_mem (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .cmd      (sbus_cmd),
    .rsp      (sbus_rsp)
  );

endmodule

`default_nettype wire

/* verilog/sbus_mem.sv */
`default_nettype none

`include "kl_mem_defs.svh"

module sbus_mem (
  input  wire                   sbus_clk,
  input  wire                   arst_n,
  input  kl_mem_pkg::sbus_cmd_t cmd,
  output kl_mem_pkg::sbus_rsp_t rsp
);

  import kl_mem_pkg::*;

  // Wide enough to hold MEM_ACK_DLY - 1
  localparam int CNT_W = $clog2(`MEM_ACK_DLY + 1);

  // Storage, parity bit on top of each word
  logic [`WORD_W:0] mem_array [0:(1 << `MEM_ADR_W) - 1];

  // Cycle in progress, between start and the answer
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             rd_q;
  logic             wr_q;
  logic             adr_ok_q;

  // Data phase, one cycle after ackn
  logic             xfer_q;

  // Latched index and read word
  mem_adr_t         idx_q;
  logic [`WORD_W:0] rd_word_q;

  // Answer cycle
  logic done;

  // Start only taken when not already busy
  logic start;

  // Odd parity over adr plus adr_par
  logic adr_par_ok;

  assign done       = busy_q && (cnt_q == '0);
  assign start      = cmd.start_a && !busy_q;
  assign adr_par_ok = ^{cmd.adr, cmd.adr_par};

  // Cycle control
  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      rd_q     <= 1'b0;
      wr_q     <= 1'b0;
      adr_ok_q <= 1'b0;
      xfer_q   <= 1'b0;
    end else begin
      // Data phase lasts one cycle
      xfer_q <= 1'b0;
      if (start) begin
        busy_q   <= 1'b1;
        cnt_q    <= CNT_W'(`MEM_ACK_DLY - 1);
        rd_q     <= cmd.rd_rq;
        wr_q     <= cmd.wr_rq;
        adr_ok_q <= adr_par_ok;
      end else if (done) begin
        busy_q <= 1'b0;
        // No data phase after an error
        xfer_q <= adr_ok_q;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Index comes from the low address bits, the rest alias
  always_ff @(posedge sbus_clk) begin
    if (start) begin
      idx_q <= cmd.adr[`MEM_ADR_W-1:0];
    end
  end

  // Read fetched at ackn, presented in the data phase
  always_ff @(posedge sbus_clk) begin
    if (done && adr_ok_q && rd_q) begin
      rd_word_q <= mem_array[idx_q];
    end
  end

  // Write on the strobe from the MBOX side
  always_ff @(posedge sbus_clk) begin
    if (xfer_q && wr_q && cmd.data_valid_a) begin
      mem_array[idx_q] <= {cmd.data_par, cmd.d};
    end
  end

  // Response strobes
  assign rsp.ackn_a       = done && adr_ok_q;
  assign rsp.error        = done && !adr_ok_q;
  assign rsp.adr_par_err  = done && !adr_ok_q;
  assign rsp.data_valid_a = xfer_q && rd_q;
  assign rsp.d            = rd_word_q[`WORD_W-1:0];
  assign rsp.data_par     = rd_word_q[`WORD_W];

endmodule

`default_nettype wire

/* verilog/mt0.sv */
`default_nettype none

// Bus translator between MBOX names and SBUS names
// The two cable copies of a real machine are folded into this one
module mt0 (
  input  wire                      sbus_clk,
  input  wire                      arst_n,
  input  kl_mem_pkg::mbox_mem_t    mbox,
  input  kl_mem_pkg::sbus_rsp_t    sbus_in,
  output kl_mem_pkg::mbox_mem_in_t mbox_in,
  output kl_mem_pkg::sbus_cmd_t    sbus_out
);

  import kl_mem_pkg::*;

  // SBUS address register
  pma_t adr_q;

  // Direction of the data lines, 1 = toward memory
  logic data_to_mem_en;

  assign data_to_mem_en = mbox.mem_data_to_mem;

  // Follows PMA while hold is high, keeps it otherwise
  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      adr_q <= '0;
    end else if (mbox.sbus_adr_hold) begin
      adr_q <= mbox.pma;
    end
  end

  // Control and status, straight renames
  assign sbus_out.start_a         = mbox.mem_start_a;
  assign sbus_out.rd_rq           = mbox.mem_rd_rq;
  assign sbus_out.wr_rq           = mbox.mem_wr_rq;
  assign sbus_out.adr_par         = mbox.mem_adr_par;
  assign sbus_out.adr             = adr_q;
  assign mbox_in.mem_ackn_a       = sbus_in.ackn_a;
  assign mbox_in.mem_error        = sbus_in.error;
  assign mbox_in.mem_adr_par_err  = sbus_in.adr_par_err;

  // Data, parity and valid steered one way at a time
  // The idle side reads 0
  always_comb begin
    if (data_to_mem_en) begin
      sbus_out.d               = mbox.mb;
      sbus_out.data_par        = mbox.mem_par;
      sbus_out.data_valid_a    = mbox.data_valid_a_out;
      mbox_in.mem_data_in      = '0;
      mbox_in.mem_par_in       = 1'b0;
      mbox_in.mem_data_valid_a = 1'b0;
    end else begin
      sbus_out.d               = '0;
      sbus_out.data_par        = 1'b0;
      sbus_out.data_valid_a    = 1'b0;
      mbox_in.mem_data_in      = sbus_in.d;
      mbox_in.mem_par_in       = sbus_in.data_par;
      mbox_in.mem_data_valid_a = sbus_in.data_valid_a;
    end
  end

endmodule

`default_nettype wire

/* verilog/mbox_mem_port.sv */
`default_nettype none

module mbox_mem_port (
  input  wire                      sbus_clk,
  input  wire                      arst_n,
  input  wire                      req,
  input  kl_mem_pkg::host_req_t    host_req,
  input  kl_mem_pkg::mbox_mem_in_t mem_in,
  output logic                     ack,
  output kl_mem_pkg::host_rsp_t    host_rsp,
  output kl_mem_pkg::mbox_mem_t    mem_out
);

  import kl_mem_pkg::*;

  mem_port_state_t state_q;

  // Request captured when a new cycle is accepted
  host_req_t req_q;

  // Response word and error flags
  word_t rsp_data_q;
  logic  adr_err_q;
  logic  dpar_err_q;

  // Odd parity over the address, diag can flip it
  logic adr_par;

  // Read word parity check, 1 when the odd count is broken
  logic rd_par_bad;

  assign adr_par    = ~(^req_q.pma) ^ req_q.bad_adr_par;
  assign rd_par_bad = ~(^{mem_in.mem_data_in, mem_in.mem_par_in});

  // Sequencer
  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        // New work only from here, so ack is already low
        IDLE: begin
          if (req) begin
            state_q <= LOAD_ADR;
          end
        end
        // Translator latches PMA at the end of this cycle
        LOAD_ADR: state_q <= START;
        // One cycle start_a strobe
        START:    state_q <= WAIT_ACK;
        // Memory answers with ackn or error, never both
        WAIT_ACK: begin
          if (mem_in.mem_error) begin
            state_q <= HOST_ACK;
          end else if (mem_in.mem_ackn_a) begin
            state_q <= XFER;
          end
        end
        // Data moves in the cycle after ackn
        XFER:     state_q <= HOST_ACK;
        // Hold ack until the host lets go of req
        HOST_ACK: begin
          if (!req) begin
            state_q <= IDLE;
          end
        end
        default:  state_q <= IDLE;
      endcase
    end
  end

  // Host request register
  always_ff @(posedge sbus_clk) begin
    if (state_q == IDLE && req) begin
      req_q <= host_req;
    end
  end

  // Error flags, cleared when a cycle is accepted
  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      adr_err_q  <= 1'b0;
      dpar_err_q <= 1'b0;
    end else if (state_q == IDLE && req) begin
      adr_err_q  <= 1'b0;
      dpar_err_q <= 1'b0;
    end else if (state_q == WAIT_ACK && mem_in.mem_error) begin
      adr_err_q  <= mem_in.mem_adr_par_err;
    end else if (state_q == XFER && !req_q.wr && mem_in.mem_data_valid_a) begin
      dpar_err_q <= rd_par_bad;
    end
  end

  // Read word capture
  always_ff @(posedge sbus_clk) begin
    if (state_q == IDLE && req) begin
      rsp_data_q <= '0;
    end else if (state_q == XFER && !req_q.wr && mem_in.mem_data_valid_a) begin
      rsp_data_q <= mem_in.mem_data_in;
    end
  end

  // MBOX bus, decoded from state
  always_comb begin
    mem_out.sbus_adr_hold    = (state_q == LOAD_ADR);
    mem_out.mem_start_a      = (state_q == START);
    mem_out.mem_rd_rq        = (state_q == START) && !req_q.wr;
    mem_out.mem_wr_rq        = (state_q == START) && req_q.wr;
    mem_out.mem_adr_par      = adr_par;
    // Drive toward memory only while write data moves
    mem_out.mem_data_to_mem  = (state_q == XFER) && req_q.wr;
    mem_out.data_valid_a_out = (state_q == XFER) && req_q.wr;
    mem_out.pma              = req_q.pma;
    mem_out.mb               = req_q.data;
    mem_out.mem_par          = ~(^req_q.data);
  end

  // Host side
  assign ack                   = (state_q == HOST_ACK);
  assign host_rsp.data         = rsp_data_q;
  assign host_rsp.adr_par_err  = adr_err_q;
  assign host_rsp.data_par_err = dpar_err_q;

endmodule

`default_nettype wire

/* verilog/kl_mem_pkg.sv */
`default_nettype none

`include "kl_mem_defs.svh"

package kl_mem_pkg;

  // Widths with a meaning of their own
  typedef logic [`WORD_W-1:0]    word_t;
  typedef logic [`PMA_W-1:0]     pma_t;
  typedef logic [`MEM_ADR_W-1:0] mem_adr_t;

  // Host side request, held stable while req is high
  typedef struct packed {
    logic  wr;           // 1 = write, 0 = read
    logic  bad_adr_par;  // Diagnostic, invert address parity
    pma_t  pma;
    word_t data;
  } host_req_t;

  // Host side response, valid while ack is high
  typedef struct packed {
    word_t data;
    logic  adr_par_err;
    logic  data_par_err;
  } host_rsp_t;

  // MBOX outputs toward the bus translator
  typedef struct packed {
    logic  mem_start_a;
    logic  mem_rd_rq;
    logic  mem_wr_rq;
    logic  mem_adr_par;
    logic  sbus_adr_hold;
    logic  mem_data_to_mem;
    logic  data_valid_a_out;
    pma_t  pma;
    word_t mb;
    logic  mem_par;
  } mbox_mem_t;

  // Translator returns to the MBOX
  typedef struct packed {
    logic  mem_ackn_a;
    logic  mem_error;
    logic  mem_adr_par_err;
    logic  mem_data_valid_a;
    word_t mem_data_in;
    logic  mem_par_in;
  } mbox_mem_in_t;

  // SBUS command side, translator to storage
  typedef struct packed {
    logic  start_a;
    logic  rd_rq;
    logic  wr_rq;
    logic  adr_par;
    pma_t  adr;
    word_t d;
    logic  data_par;
    logic  data_valid_a;  // Write strobe
  } sbus_cmd_t;

  // SBUS response side, storage to translator
  typedef struct packed {
    logic  ackn_a;
    logic  error;
    logic  adr_par_err;
    logic  data_valid_a;
    word_t d;
    logic  data_par;
  } sbus_rsp_t;

  // Memory port sequencer
  typedef enum logic [2:0] {
    IDLE,
    LOAD_ADR,
    START,
    WAIT_ACK,
    XFER,
    HOST_ACK
  } mem_port_state_t;

endpackage

`default_nettype wire

/* verilog/kl_mem_defs.svh */
`ifndef KL_MEM_DEFS_SVH
`define KL_MEM_DEFS_SVH

// Width of a KL10 data word
`define WORD_W 36

// Physical memory address width as seen on the SBUS
`define PMA_W 22

// Low PMA bits that index storage
// Upper PMA bits alias onto the same 256 words
`define MEM_ADR_W 8

// Cycles from start_a to ackn_a or error inside the storage module
// Must be at least 1
`define MEM_ACK_DLY 2

`endif
